// ==== list.f ====
+incdir+rtl
rtl/req_shim_pkg.sv
rtl/req_fifo_lutram.sv
rtl/req_buffer_lockstep.sv
rtl/req_sink_mem.sv
rtl/req_shim_csr.sv
rtl/req_shim_top.sv
dv/req_shim_chk.sv
dv/req_shim_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the request shim testbench with Verilator and runs it.
# Exits non-zero if the build fails, the simulation aborts or the log reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert --timescale 1ns/10ps --top-module req_shim_tb \
    -f list.f --Mdir "$BUILD_DIR" -o req_shim_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/req_shim_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "Simulation log holds no final verdict"
    exit 1
fi
exit 0

// ==== dv/req_shim_tb.sv ====
// Testbench of the request shim
//   Clock, reset, watchdog, APB and request beat tasks
//   Reference memory model and read response comparison
//   Register, ordering, back-pressure and drain tests

`timescale 1ns/10ps

`include "req_shim_config.svh"

module req_shim_tb;

    import req_shim_pkg::*;

    // The five tests take a few hundred cycles and the limit leaves a wide margin
    localparam int CYCLE_LIMIT = 2000;
    localparam int DEPTH       = `REQ_FIFO_DEPTH;

    logic        clk;
    logic        arst_n;
    t_csr_addr   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    t_rd_req     rd_req;
    t_wr_req     wr_req;
    logic        almost_full;
    logic        rd_rsp_valid;
    t_req_data   rd_rsp_data;

    logic [31:0] lfsr;
    t_req_data   ref_mem [`REQ_MEM_WORDS];
    t_req_data   exp_q [$];
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          n_reads = 0;
    int          n_writes = 0;

    req_shim_top dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================
    // Reference model and checks
    // ========================================

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Applies one beat in execution order, write first, and returns what its read sees
    function automatic t_req_data model_beat(input logic wv, input t_req_addr wa,
                                             input t_req_data wd, input t_req_addr ra);
        if (wv)
            ref_mem[wa] = wd;
        return ref_mem[ra];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // Responses leave the sink in issue order, so the oldest expected word is next
    always @(negedge clk)
    begin
        if (arst_n && rd_rsp_valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("Read response at %0t ns with no read outstanding", $time);
            end
            if (exp_q.size() != 0)
                check_value("read response", rd_rsp_data, exp_q.pop_front());
        end
    end

    // ========================================
    // Bus and request tasks
    // ========================================

    task automatic apb_xfer(input logic wr, input t_csr_addr addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        @(posedge clk);
        paddr  <= addr;
        pwrite <= wr;
        pwdata <= wdata;
        psel   <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
        // Sample in the middle of the access phase
        @(negedge clk);
        rdata = prdata;
        // No wait states, so the transfer must complete in this access phase
        check_value($sformatf("pready at 0x%02h", addr), {31'b0, pready}, 32'd1);
        check_value($sformatf("pslverr at 0x%02h", addr), {31'b0, pslverr}, {31'b0, exp_err});
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_expect(input t_csr_addr addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] rdata;
        apb_xfer(1'b0, addr, '0, 1'b0, rdata);
        check_value(what, rdata, exp);
    endtask

    // Waits out almost_full, then holds the beat for one cycle
    task automatic issue_beat(input logic rv, input t_req_addr ra, input logic wv,
                              input t_req_addr wa, input t_req_data wd);
        t_req_data exp;
        exp = model_beat(wv, wa, wd, ra);
        if (rv)
        begin
            exp_q.push_back(exp);
            n_reads++;
        end
        if (wv)
            n_writes++;
        @(negedge clk);
        while (almost_full)
            @(negedge clk);
        @(posedge clk);
        rd_req <= {rv, ra};
        wr_req <= {wv, wa, wd};
        @(posedge clk);
        rd_req <= '0;
        wr_req <= '0;
    endtask

    task automatic random_beat();
        logic rv;
        logic wv;
        rv = 1'(rand_bits(1));
        wv = 1'(rand_bits(1));
        // A beat with neither channel set would not be stored
        issue_beat(rv || !wv, t_req_addr'(rand_bits(`REQ_ADDR_BITS)), wv,
                   t_req_addr'(rand_bits(`REQ_ADDR_BITS)),
                   t_req_data'(rand_bits(`REQ_DATA_BITS)));
    endtask

    // Waits for an empty FIFO first and then for the last response
    task automatic wait_drained();
        logic [31:0] occ;
        occ = 32'd1;
        while (occ != 0)
            apb_xfer(1'b0, CSR_STATUS, '0, 1'b0, occ);
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic check_fill(input int count, input int thr);
        logic [31:0] occ;
        apb_xfer(1'b0, CSR_STATUS, '0, 1'b0, occ);
        check_value("STATUS", occ, 32'(count));
        @(negedge clk);
        check_value("almost_full", {31'b0, almost_full}, {31'b0, count >= DEPTH - thr});
    endtask

    // Beats one at a time until the flag is due, checking occupancy and flag after each
    task automatic fill_to_mark(inout int count, input int thr);
        while (count < DEPTH - thr)
        begin
            random_beat();
            count++;
            check_fill(count, thr);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        logic [31:0] rdata;
        int          mark;
        int          count;
        t_req_addr   a;

        arst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        rd_req  = '0;
        wr_req  = '0;
        lfsr    = 32'hcc265ee0;
        for (int i = 0; i < `REQ_MEM_WORDS; i++)
            ref_mem[i] = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        mark = errors;
        read_expect(CSR_CTRL, 32'd0, "CTRL");
        read_expect(CSR_THRESH, 32'(`REQ_THRESH_RESET), "THRESH");
        read_expect(CSR_STATUS, 32'd0, "STATUS");
        read_expect(CSR_RD_COUNT, 32'd0, "RD_COUNT");
        read_expect(CSR_WR_COUNT, 32'd0, "WR_COUNT");
        apb_xfer(1'b0, 8'h14, '0, 1'b1, rdata);
        apb_xfer(1'b1, 8'h40, 32'd1, 1'b1, rdata);
        apb_xfer(1'b1, CSR_STATUS, 32'd5, 1'b1, rdata);
        read_expect(CSR_STATUS, 32'd0, "STATUS after write");
        report_test(1, "register reset values and errors", mark);

        // Writes scatter over the memory, then every address is read back
        mark = errors;
        apb_xfer(1'b1, CSR_CTRL, 32'd1, 1'b0, rdata);
        repeat (12)
        begin
            a = t_req_addr'(rand_bits(`REQ_ADDR_BITS));
            issue_beat(1'b0, '0, 1'b1, a, t_req_data'(rand_bits(`REQ_DATA_BITS)));
        end
        for (int i = 0; i < `REQ_MEM_WORDS; i++)
            issue_beat(1'b1, t_req_addr'(i), 1'b0, '0, '0);
        repeat (8) random_beat();
        wait_drained();
        report_test(2, "random writes and reads", mark);

        mark = errors;
        repeat (4)
        begin
            a = t_req_addr'(rand_bits(`REQ_ADDR_BITS));
            issue_beat(1'b1, a, 1'b1, a, t_req_data'(rand_bits(`REQ_DATA_BITS)));
        end
        wait_drained();
        report_test(3, "write before read in one beat", mark);

        // Sink held off, so every beat stays in the FIFO
        mark = errors;
        apb_xfer(1'b1, CSR_CTRL, 32'd0, 1'b0, rdata);
        count = 0;
        check_fill(count, `REQ_THRESH_RESET);
        fill_to_mark(count, `REQ_THRESH_RESET);
        // A zero threshold moves the mark to a completely full FIFO
        apb_xfer(1'b1, CSR_THRESH, 32'd0, 1'b0, rdata);
        check_fill(count, 0);
        fill_to_mark(count, 0);
        report_test(4, "back-pressure and almost_full", mark);

        mark = errors;
        apb_xfer(1'b1, CSR_CTRL, 32'd1, 1'b0, rdata);
        wait_drained();
        read_expect(CSR_RD_COUNT, 32'(n_reads), "RD_COUNT");
        read_expect(CSR_WR_COUNT, 32'(n_writes), "WR_COUNT");
        report_test(5, "drain and counters", mark);

        $display("checks %0d, errors %0d, reads %0d, writes %0d",
                 checks, errors, n_reads, n_writes);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== dv/req_shim_chk.sv ====
// Concurrent checks bound into the request shim top level
//   No enqueue into a full FIFO
//   Read response exactly one cycle after a consumed read
//   Quiet outputs in the first cycle after reset

`timescale 1ns/10ps

`include "req_shim_config.svh"

module req_shim_chk
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  req_shim_pkg::t_rd_req   rd_req,
    input  req_shim_pkg::t_wr_req   wr_req,
    input  req_shim_pkg::t_fifo_cnt occupancy,
    input  req_shim_pkg::t_rd_req   head_rd,
    input  logic                    deq,
    input  logic                    almost_full,
    input  logic                    sink_enable,
    input  logic                    pslverr,
    input  logic                    rd_rsp_valid
);

    import req_shim_pkg::*;

    localparam t_fifo_cnt DEPTH = t_fifo_cnt'(`REQ_FIFO_DEPTH);

    // A full FIFO must not see a new beat from the client
    no_enq_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        (occupancy == DEPTH) |-> !(rd_req.valid || wr_req.valid))
        else $error("Request beat presented while the FIFO is full");

    // Every consumed read gives a response in the next cycle
    rsp_after_read: assert property (@(posedge clk) disable iff (!arst_n)
        (deq && head_rd.valid) |=> rd_rsp_valid)
        else $error("Consumed read produced no response");

    // And no response appears without such a read
    rsp_has_read: assert property (@(posedge clk) disable iff (!arst_n)
        rd_rsp_valid |-> $past(deq && head_rd.valid))
        else $error("Read response without a consumed read");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !(almost_full || deq || rd_rsp_valid || sink_enable || pslverr))
        else $error("Outputs not at their reset values after reset release");

endmodule

bind req_shim_top req_shim_chk u_chk
(
    .clk,
    .arst_n,
    .rd_req,
    .wr_req,
    .occupancy,
    .head_rd,
    .deq,
    .almost_full,
    .sink_enable,
    .pslverr,
    .rd_rsp_valid
);

// ==== rtl/req_shim_top.sv ====
// Top level of the request shim
//   APB register block steering the sink and the threshold
//   Lockstep request buffer in front of the memory target

`timescale 1ns/10ps

module req_shim_top
(
    input  logic                    clk,
    input  logic                    arst_n,

    // APB slave
    input  req_shim_pkg::t_csr_addr paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,

    // Client requests and flow control
    input  req_shim_pkg::t_rd_req   rd_req,
    input  req_shim_pkg::t_wr_req   wr_req,
    output logic                    almost_full,

    // Read responses
    output logic                    rd_rsp_valid,
    output req_shim_pkg::t_req_data rd_rsp_data
);

    import req_shim_pkg::*;

    logic      sink_enable;
    t_fifo_cnt thresh;
    t_fifo_cnt occupancy;
    t_rd_req   head_rd;
    t_wr_req   head_wr;
    logic      deq;
    logic      rd_done;
    logic      wr_done;

    req_shim_csr u_csr
    (
        .clk, .arst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .occupancy, .rd_done, .wr_done,
        .sink_enable, .thresh
    );

    // Both channels enter here and leave together at the head
    req_buffer_lockstep u_buffer
    (
        .clk, .arst_n,
        .rd_req, .wr_req, .thresh,
        .deq, .head_rd, .head_wr,
        .almost_full, .occupancy
    );

    req_sink_mem u_sink
    (
        .clk, .arst_n,
        .sink_enable, .head_rd, .head_wr, .deq,
        .rd_done, .wr_done,
        .rd_rsp_valid, .rd_rsp_data
    );

endmodule

// ==== rtl/req_shim_csr.sv ====
// APB register block of the request shim
//   CTRL and THRESH control registers
//   STATUS occupancy and the read and write counters
//   Error response for unmapped offsets and read-only writes

`timescale 1ns/10ps

`include "req_shim_config.svh"

module req_shim_csr
(
    input  logic                      clk,
    input  logic                      arst_n,

    // APB slave
    input  req_shim_pkg::t_csr_addr   paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,

    // Status and completion inputs
    input  req_shim_pkg::t_fifo_cnt   occupancy,
    input  logic                      rd_done,
    input  logic                      wr_done,

    // Control outputs
    output logic                      sink_enable,
    output req_shim_pkg::t_fifo_cnt   thresh
);

    import req_shim_pkg::*;

    logic        access;
    logic        mapped;
    logic        read_only;
    logic        wr_ok;
    logic [31:0] rd_count;
    logic [31:0] wr_count;

    // ========================================
    // Decode
    // ========================================

    // Zero wait states, every transfer ends in its access phase
    assign pready = 1'b1;
    assign access = psel && penable;

    always_comb
    begin
        mapped    = 1'b1;
        read_only = 1'b1;
        case (paddr)
            CSR_CTRL, CSR_THRESH:                 read_only = 1'b0;
            CSR_STATUS, CSR_RD_COUNT, CSR_WR_COUNT: read_only = 1'b1;
            default:                              mapped    = 1'b0;
        endcase
    end

    assign pslverr = access && (!mapped || (pwrite && read_only));
    assign wr_ok   = access && pwrite && mapped && !read_only;

    // ========================================
    // Registers and counters
    // ========================================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sink_enable <= 1'b0;
            thresh      <= t_fifo_cnt'(`REQ_THRESH_RESET);
            rd_count    <= '0;
            wr_count    <= '0;
        end
        else
        begin
            if (wr_ok && (paddr == CSR_CTRL))
            begin
                sink_enable <= pwdata[0];
            end
            if (wr_ok && (paddr == CSR_THRESH))
            begin
                thresh <= pwdata[$bits(t_fifo_cnt)-1:0];
            end
            // Counters only move on completions and clear only at reset
            if (rd_done)
            begin
                rd_count <= rd_count + 32'd1;
            end
            if (wr_done)
            begin
                wr_count <= wr_count + 32'd1;
            end
        end
    end

    // Read data, zero for unmapped offsets
    always_comb
    begin
        prdata = '0;
        case (paddr)
            CSR_CTRL:     prdata[0] = sink_enable;
            CSR_THRESH:   prdata[$bits(t_fifo_cnt)-1:0] = thresh;
            CSR_STATUS:   prdata[$bits(t_fifo_cnt)-1:0] = occupancy;
            CSR_RD_COUNT: prdata = rd_count;
            CSR_WR_COUNT: prdata = wr_count;
            default:      prdata = '0;
        endcase
    end

endmodule

// ==== rtl/req_sink_mem.sv ====
// Memory target behind the request buffer
//   Dequeues one entry per cycle while enabled
//   Applies the write of an entry before its read
//   Registered read response and completion pulses for the counters

`timescale 1ns/10ps

`include "req_shim_config.svh"

module req_sink_mem
(
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    sink_enable,
    input  req_shim_pkg::t_rd_req   head_rd,
    input  req_shim_pkg::t_wr_req   head_wr,
    output logic                    deq,

    // Completion pulses, high in the cycle the entry is consumed
    output logic                    rd_done,
    output logic                    wr_done,

    // Response path without back-pressure
    output logic                    rd_rsp_valid,
    output req_shim_pkg::t_req_data rd_rsp_data
);

    import req_shim_pkg::*;

    t_req_data mem [`REQ_MEM_WORDS];
    t_req_data rd_word;
    logic      wr_hit;

    // ========================================
    // Dequeue control
    // ========================================

    // Head valids are already masked by the buffer, so any valid means an entry
    assign deq     = sink_enable && (head_rd.valid || head_wr.valid);
    assign rd_done = deq && head_rd.valid;
    assign wr_done = deq && head_wr.valid;

    // ========================================
    // Memory and read path
    // ========================================

    // The write of the same entry lands first, so its data wins on a match
    assign wr_hit  = head_wr.valid && (head_wr.addr == head_rd.addr);
    assign rd_word = wr_hit ? head_wr.data : mem[head_rd.addr];

    // Memory starts out all zero so unwritten addresses read back zero
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `REQ_MEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (wr_done)
        begin
            mem[head_wr.addr] <= head_wr.data;
        end
    end

    // Response valid one cycle after the read is consumed
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_rsp_valid <= 1'b0;
        end
        else
        begin
            rd_rsp_valid <= rd_done;
        end
    end

    // Data holds its last value between responses
    always_ff @(posedge clk)
    begin
        if (rd_done)
        begin
            rd_rsp_data <= rd_word;
        end
    end

endmodule

// ==== rtl/req_buffer_lockstep.sv ====
// Lockstep request buffer
//   Read and write beats share one FIFO entry and keep their order
//   Head outputs with valids masked while the FIFO is empty
//   Almost-full and occupancy passed out from the FIFO

`timescale 1ns/10ps

`include "req_shim_config.svh"

module req_buffer_lockstep
(
    input  logic                  clk,
    input  logic                  arst_n,

    // Unbuffered client beats
    input  req_shim_pkg::t_rd_req rd_req,
    input  req_shim_pkg::t_wr_req wr_req,
    input  req_shim_pkg::t_fifo_cnt thresh,

    // One dequeue moves both channels
    input  logic                  deq,
    output req_shim_pkg::t_rd_req head_rd,
    output req_shim_pkg::t_wr_req head_wr,

    output logic                  almost_full,
    output req_shim_pkg::t_fifo_cnt occupancy
);

    import req_shim_pkg::*;

    localparam int ENTRY_BITS = $bits(t_rd_req) + $bits(t_wr_req);

    logic                  enq_en;
    logic                  not_empty;
    logic [ENTRY_BITS-1:0] first;

    // A beat is stored when either channel carries a request
    assign enq_en = rd_req.valid || wr_req.valid;

    // Split the head entry back into its two channels
    always_comb
    begin
        {head_rd, head_wr} = first;
        // The stored valids are stale while the FIFO is empty
        head_rd.valid = head_rd.valid && not_empty;
        head_wr.valid = head_wr.valid && not_empty;
    end

    req_fifo_lutram
    #(
        .N_DATA_BITS (ENTRY_BITS),
        .N_ENTRIES   (`REQ_FIFO_DEPTH)
    )
    u_fifo
    (
        .clk,
        .arst_n,
        // Field order must match the split of first above
        .enq_data    ({rd_req, wr_req}),
        .enq_en,
        .thresh,
        .deq_en      (deq),
        .first,
        .not_empty,
        .almost_full,
        .occupancy
    );

endmodule

// ==== rtl/req_fifo_lutram.sv ====
// Request FIFO built on a small distributed memory
//   Explicit dequeue, head word visible while not empty
//   Occupancy counter and registered almost-full flag
//   against a run-time threshold of free slots

`timescale 1ns/10ps

`include "req_shim_config.svh"

module req_fifo_lutram
#(
    parameter int N_DATA_BITS = `REQ_DATA_BITS,
    parameter int N_ENTRIES   = `REQ_FIFO_DEPTH
)
(
    input  logic                               clk,
    input  logic                               arst_n,

    input  logic [N_DATA_BITS-1:0]             enq_data,
    input  logic                               enq_en,
    input  logic [$clog2(N_ENTRIES + 1)-1:0]   thresh,

    input  logic                               deq_en,
    output logic [N_DATA_BITS-1:0]             first,
    output logic                               not_empty,

    output logic                               almost_full,
    output logic [$clog2(N_ENTRIES + 1)-1:0]   occupancy
);

    localparam int PTR_BITS = $clog2(N_ENTRIES);
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Almost full once occupancy + thresh reaches the depth
    localparam logic [CNT_BITS:0] FULL_MARK = (CNT_BITS + 1)'(N_ENTRIES);
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(N_ENTRIES - 1);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    cnt_q;
    logic [CNT_BITS-1:0]    cnt_nxt;

    // ========================================
    // Storage
    // ========================================

    // Payload only, the pointers say which slots hold live data
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    assign first     = mem[rd_ptr];
    assign not_empty = (cnt_q != '0);
    assign occupancy = cnt_q;

    // ========================================
    // Pointers and occupancy
    // ========================================

    always_comb
    begin
        case ({enq_en, deq_en})
            2'b10:   cnt_nxt = cnt_q + 1'b1;
            2'b01:   cnt_nxt = cnt_q - 1'b1;
            default: cnt_nxt = cnt_q;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            cnt_q       <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            cnt_q <= cnt_nxt;

            // Taken from the next count so the flag lines up with occupancy
            almost_full <= ({1'b0, cnt_nxt} + {1'b0, thresh}) >= FULL_MARK;
        end
    end

endmodule

// ==== rtl/req_shim_pkg.sv ====
// Shared types of the request shim
//   Address and data words, read and write request beats
//   FIFO occupancy count and APB register offsets

package req_shim_pkg;

`include "req_shim_config.svh"

    typedef logic [`REQ_ADDR_BITS-1:0] t_req_addr;
    typedef logic [`REQ_DATA_BITS-1:0] t_req_data;

    // Channel 0 beat, a read of one word
    typedef struct packed {
        logic      valid;
        t_req_addr addr;
    } t_rd_req;

    // Channel 1 beat, a write of one word
    typedef struct packed {
        logic      valid;
        t_req_addr addr;
        t_req_data data;
    } t_wr_req;

    // Holds every occupancy from empty to full, so one bit more than the pointer
    typedef logic [$clog2(`REQ_FIFO_DEPTH + 1)-1:0] t_fifo_cnt;

    // APB byte offset
    typedef logic [7:0] t_csr_addr;

    // Register map
    localparam t_csr_addr CSR_CTRL     = 8'h00;
    localparam t_csr_addr CSR_THRESH   = 8'h04;
    localparam t_csr_addr CSR_STATUS   = 8'h08;
    localparam t_csr_addr CSR_RD_COUNT = 8'h0C;
    localparam t_csr_addr CSR_WR_COUNT = 8'h10;

endpackage

// ==== rtl/req_shim_config.svh ====
// Build-time configuration of the request shim
//   FIFO depth and reset value of the almost-full threshold
//   Word address and data widths of the memory target
//   Memory size derived from the address width

`ifndef REQ_SHIM_CONFIG_SVH
`define REQ_SHIM_CONFIG_SVH

// Number of entries in the lockstep request FIFO
`define REQ_FIFO_DEPTH 8

// Word address and data widths of the target memory
`define REQ_ADDR_BITS 4
`define REQ_DATA_BITS 32

// One word per address
`define REQ_MEM_WORDS (1 << `REQ_ADDR_BITS)

// Free-slot threshold loaded into THRESH at reset
`define REQ_THRESH_RESET 2

`endif
